//--- Bender.yml
package:
  name: hdmi_tx

sources:
  # shared packages
  - common/video_pkg.sv
  - common/tmds_pkg.sv
  # design
  - hdl/video_sig_gen.sv
  - tmds/tmds_encoder.sv
  - hdl/hdmi_tx_top.sv
  # testbench
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_hdmi_tx_top.sv

//--- common/tmds_pkg.sv
package tmds_pkg;

    // one colour channel value
    typedef logic [7:0] pixel_t;

    // encoded symbol, bit 9 goes out last on the wire
    typedef logic [9:0] symbol_t;

    // control pair, {c1, c0}
    typedef logic [1:0] ctrl_t;

    // running disparity in bits
    // stays within +/-8, so 5 bits signed is enough
    typedef logic signed [4:0] disparity_t;

    // control-period codes
    // written msb first
    localparam symbol_t ctrl_code_00 = 10'b1101010100;
    localparam symbol_t ctrl_code_01 = 10'b0010101011;
    localparam symbol_t ctrl_code_10 = 10'b0101010100;
    localparam symbol_t ctrl_code_11 = 10'b1010101011;

    // the disparity limit assertions check against
    localparam int disparity_max = 8;

    // a 10-bit symbol holds at most 10 ones
    // any count of an 8-bit word fits in 4 bits
    typedef logic [3:0] ones_t;

endpackage

//--- common/video_pkg.sv
package video_pkg;

    // raster coordinates and frame counter
    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [5:0]  frame_t;

    // 720p horizontal timing, in pixels
    localparam int h_active = 1280;
    localparam int h_front  = 110;
    localparam int h_sync   = 40;
    localparam int h_total  = 1650;

    // 720p vertical timing, in lines
    localparam int v_active = 720;
    localparam int v_front  = 5;
    localparam int v_sync   = 5;
    localparam int v_total  = 750;

    // sync windows, bounds inclusive
    localparam int h_sync_start = h_active + h_front;
    localparam int h_sync_stop  = h_sync_start + h_sync - 1;
    localparam int v_sync_start = v_active + v_front;
    localparam int v_sync_stop  = v_sync_start + v_sync - 1;

    // frame counter wraps once a second at 60 Hz
    localparam int frames_per_wrap = 60;

    // fallback gray when no rasterizer pixel is chosen
    localparam logic [7:0] flat_shade = 8'hCC;

endpackage

//--- hdl/hdmi_tx_top.sv
`timescale 1ns/1ps

module hdmi_tx_top (
    input  logic               clk_pixel,
    input  logic               rst_n,
    input  tmds_pkg::pixel_t   gray,
    input  logic               shade_sel,
    output video_pkg::hcount_t hcount,
    output video_pkg::vcount_t vcount,
    output logic               hs,
    output logic               vs,
    output logic               ad,
    output logic               nf,
    output video_pkg::frame_t  fc,
    output tmds_pkg::symbol_t  tmds_red,
    output tmds_pkg::symbol_t  tmds_green,
    output tmds_pkg::symbol_t  tmds_blue
);

    // value shared by all three channels
    tmds_pkg::pixel_t pixel;

    // rasterizer gray or the flat shade
    assign pixel = shade_sel ? gray : video_pkg::flat_shade;

    // raster timing
    video_sig_gen u_video_sig_gen (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .hcount    (hcount),
        .vcount    (vcount),
        .hs        (hs),
        .vs        (vs),
        .ad        (ad),
        .nf        (nf),
        .fc        (fc)
    );

    // red and green carry no control info
    tmds_encoder u_tmds_red (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .data      (pixel),
        .control   (2'b00),
        .ve        (ad),
        .tmds      (tmds_red)
    );

    tmds_encoder u_tmds_green (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .data      (pixel),
        .control   (2'b00),
        .ve        (ad),
        .tmds      (tmds_green)
    );

    // blue channel carries the syncs during blanking
    tmds_encoder u_tmds_blue (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .data      (pixel),
        .control   ({vs, hs}),
        .ve        (ad),
        .tmds      (tmds_blue)
    );

endmodule

//--- hdl/video_sig_gen.sv
`timescale 1ns/1ps

module video_sig_gen (
    input  logic              clk_pixel,
    input  logic              rst_n,
    output video_pkg::hcount_t hcount,
    output video_pkg::vcount_t vcount,
    output logic              hs,
    output logic              vs,
    output logic              ad,
    output logic              nf,
    output video_pkg::frame_t  fc
);

    // next raster position
    video_pkg::hcount_t hcount_next;
    video_pkg::vcount_t vcount_next;

    // end of line and end of frame
    logic h_wrap;
    logic v_wrap;

    assign h_wrap = (hcount == video_pkg::hcount_t'(video_pkg::h_total - 1));
    assign v_wrap = (vcount == video_pkg::vcount_t'(video_pkg::v_total - 1));

    // horizontal counter runs every cycle
    always_comb begin
        if (h_wrap) begin
            hcount_next = '0;
        end else begin
            hcount_next = hcount + 1'b1;
        end
    end

    // vertical counter only steps at end of line
    always_comb begin
        vcount_next = vcount;
        if (h_wrap) begin
            if (v_wrap) begin
                vcount_next = '0;
            end else begin
                vcount_next = vcount + 1'b1;
            end
        end
    end

    // flags come from the next counts
    // so once registered they sit in the same cycle as hcount/vcount
    always_ff @(posedge clk_pixel) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
            hs     <= 1'b0;
            vs     <= 1'b0;
            ad     <= 1'b0;
            nf     <= 1'b0;
        end else begin
            hcount <= hcount_next;
            vcount <= vcount_next;
            // hsync window 1390..1429
            hs <= (hcount_next >= video_pkg::hcount_t'(video_pkg::h_sync_start)) &&
                  (hcount_next <= video_pkg::hcount_t'(video_pkg::h_sync_stop));
            // vsync window 725..729
            vs <= (vcount_next >= video_pkg::vcount_t'(video_pkg::v_sync_start)) &&
                  (vcount_next <= video_pkg::vcount_t'(video_pkg::v_sync_stop));
            // visible region
            ad <= (hcount_next < video_pkg::hcount_t'(video_pkg::h_active)) &&
                  (vcount_next < video_pkg::vcount_t'(video_pkg::v_active));
            // first blanking pixel after the last visible line
            nf <= (hcount_next == video_pkg::hcount_t'(video_pkg::h_active)) &&
                  (vcount_next == video_pkg::vcount_t'(video_pkg::v_active));
        end
    end

    // frame counter steps the cycle after nf
    always_ff @(posedge clk_pixel) begin
        if (!rst_n) begin
            fc <= '0;
        end else if (nf) begin
            if (fc == video_pkg::frame_t'(video_pkg::frames_per_wrap - 1)) begin
                fc <= '0;
            end else begin
                fc <= fc + 1'b1;
            end
        end
    end

    // counter never leaves the raster
    hcount_in_range: assert property (
        @(posedge clk_pixel) disable iff (!rst_n)
        hcount < video_pkg::hcount_t'(video_pkg::h_total)
    ) else $error("hcount %0d out of range", hcount);

    // one pulse per frame, never back to back
    nf_single_cycle: assert property (
        @(posedge clk_pixel) disable iff (!rst_n)
        nf |=> !nf
    ) else $error("nf held for more than one cycle");

endmodule

//--- tmds/tmds_encoder.sv
`timescale 1ns/1ps

module tmds_encoder (
    input  logic              clk_pixel,
    input  logic              rst_n,
    input  tmds_pkg::pixel_t  data,
    input  tmds_pkg::ctrl_t   control,
    input  logic              ve,
    output tmds_pkg::symbol_t tmds
);

    // ones in the incoming byte
    tmds_pkg::ones_t n1_d;
    // pick xnor chaining for ones-heavy bytes
    logic use_xnor;
    // transition-minimized word
    // bit 8 is 1 for xor, 0 for xnor
    logic [8:0] q_m;
    // ones and zeros in q_m[7:0]
    tmds_pkg::ones_t n1_q;
    tmds_pkg::ones_t n0_q;
    // ones minus zeros of q_m[7:0]
    int bal;
    // running disparity and its update
    tmds_pkg::disparity_t disp;
    int disp_next;
    // data symbol and control symbol candidates
    tmds_pkg::symbol_t sym_next;
    tmds_pkg::symbol_t ctrl_sym;

    // stage one

    always_comb begin
        n1_d = '0;
        for (int i = 0; i < 8; i++) begin
            n1_d = n1_d + tmds_pkg::ones_t'(data[i]);
        end
    end

    // dvi rule, tie at four ones broken by data[0]
    assign use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !data[0]);

    always_comb begin
        q_m[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            if (use_xnor) begin
                q_m[i] = ~(q_m[i-1] ^ data[i]);
            end else begin
                q_m[i] = q_m[i-1] ^ data[i];
            end
        end
        q_m[8] = ~use_xnor;
    end

    // stage two

    always_comb begin
        n1_q = '0;
        for (int i = 0; i < 8; i++) begin
            n1_q = n1_q + tmds_pkg::ones_t'(q_m[i]);
        end
        n0_q = 4'd8 - n1_q;
        bal  = int'(n1_q) - int'(n0_q);
    end

    // inversion choice against the running disparity
    always_comb begin
        if ((disp == 0) || (bal == 0)) begin
            // no bias yet, or word is balanced
            // bit 9 is just the complement of bit 8
            sym_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            if (q_m[8]) begin
                disp_next = int'(disp) + bal;
            end else begin
                disp_next = int'(disp) - bal;
            end
        end else if (((disp > 0) && (bal > 0)) || ((disp < 0) && (bal < 0))) begin
            // word would push disparity further the same way, invert it
            sym_next  = {1'b1, q_m[8], ~q_m[7:0]};
            disp_next = int'(disp) + (q_m[8] ? 2 : 0) - bal;
        end else begin
            // word already pulls back toward zero
            sym_next  = {1'b0, q_m[8], q_m[7:0]};
            disp_next = int'(disp) - (q_m[8] ? 0 : 2) + bal;
        end
    end

    // blanking symbols
    always_comb begin
        case (control)
            2'b00:   ctrl_sym = tmds_pkg::ctrl_code_00;
            2'b01:   ctrl_sym = tmds_pkg::ctrl_code_01;
            2'b10:   ctrl_sym = tmds_pkg::ctrl_code_10;
            default: ctrl_sym = tmds_pkg::ctrl_code_11;
        endcase
    end

    // one register stage, symbol out one cycle after data in
    always_ff @(posedge clk_pixel) begin
        if (!rst_n) begin
            tmds <= '0;
            disp <= '0;
        end else if (ve) begin
            tmds <= sym_next;
            disp <= tmds_pkg::disparity_t'(disp_next);
        end else begin
            // control period restarts dc balance
            tmds <= ctrl_sym;
            disp <= '0;
        end
    end

    // dc balance holds across the whole video period
    disparity_bounded: assert property (
        @(posedge clk_pixel) disable iff (!rst_n)
        (disp >= -tmds_pkg::disparity_max) && (disp <= tmds_pkg::disparity_max)
    ) else $error("running disparity %0d out of bounds", disp);

endmodule

//--- verif/tb_tmds_model.svh
`ifndef TB_TMDS_MODEL_SVH
`define TB_TMDS_MODEL_SVH

// count of ones in a byte
function automatic int ones_in_byte(input logic [7:0] v);
    int n;
    n = 0;
    for (int i = 0; i < 8; i++) begin
        n = n + int'(v[i]);
    end
    return n;
endfunction

// transition minimizing, DVI stage one
function automatic logic [8:0] model_qm(input logic [7:0] d);
    logic [8:0] q;
    logic xnor_mode;
    int n1;
    n1 = ones_in_byte(d);
    // xnor for more than four ones, or exactly four with d[0] low
    xnor_mode = (n1 > 4) || ((n1 == 4) && (d[0] == 1'b0));
    q[0] = d[0];
    for (int i = 1; i < 8; i++) begin
        q[i] = xnor_mode ? ~(q[i-1] ^ d[i]) : (q[i-1] ^ d[i]);
    end
    q[8] = xnor_mode ? 1'b0 : 1'b1;
    return q;
endfunction

// final 10-bit symbol for a q_m word and the running disparity
function automatic logic [9:0] model_symbol(input logic [8:0] qm, input int disp);
    int n1;
    int n0;
    n1 = ones_in_byte(qm[7:0]);
    n0 = 8 - n1;
    if ((disp == 0) || (n1 == n0)) begin
        return {~qm[8], qm[8], (qm[8] ? qm[7:0] : ~qm[7:0])};
    end else if (((disp > 0) && (n1 > n0)) || ((disp < 0) && (n0 > n1))) begin
        return {1'b1, qm[8], ~qm[7:0]};
    end
    return {1'b0, qm[8], qm[7:0]};
endfunction

// disparity after sending the symbol above
function automatic int model_disparity(input logic [8:0] qm, input int disp);
    int n1;
    int n0;
    n1 = ones_in_byte(qm[7:0]);
    n0 = 8 - n1;
    if ((disp == 0) || (n1 == n0)) begin
        return qm[8] ? disp + (n1 - n0) : disp + (n0 - n1);
    end else if (((disp > 0) && (n1 > n0)) || ((disp < 0) && (n0 > n1))) begin
        return disp + (qm[8] ? 2 : 0) + (n0 - n1);
    end
    return disp - (qm[8] ? 0 : 2) + (n1 - n0);
endfunction

// blanking codes, bit 9 first
function automatic logic [9:0] model_ctrl(input logic [1:0] c);
    case (c)
        2'b00:   return 10'b1101010100;
        2'b01:   return 10'b0010101011;
        2'b10:   return 10'b0101010100;
        default: return 10'b1010101011;
    endcase
endfunction

`endif

//--- verif/tb_hdmi_tx_top.sv
`timescale 1ns/1ps

module tb_hdmi_tx_top;

    // run length in pixel clocks
    localparam int reset_cycles = 10;
    localparam int line_cycles  = 1650;
    localparam int frame_cycles = 1650 * 750;
    localparam int cycle_limit  = reset_cycles + 2 * frame_cycles + 20000;
    localparam int table_len    = 16;

    logic               clk_pixel;
    logic               rst_n;
    tmds_pkg::pixel_t   gray;
    logic               shade_sel;
    video_pkg::hcount_t hcount;
    video_pkg::vcount_t vcount;
    logic               hs;
    logic               vs;
    logic               ad;
    logic               nf;
    video_pkg::frame_t  fc;
    tmds_pkg::symbol_t  tmds_red;
    tmds_pkg::symbol_t  tmds_green;
    tmds_pkg::symbol_t  tmds_blue;

    integer seed;
    int     cycle_count = 0;
    string  test_name;

    // expected values at the current falling edge
    int                exp_h;
    int                exp_v;
    int                exp_fc;
    logic              exp_hs;
    logic              exp_vs;
    logic              exp_ad;
    logic              exp_nf;
    tmds_pkg::symbol_t exp_sym [3];
    // running disparity per channel, red green blue
    int                disp [3];
    // position within the current run of active pixels
    int                px_idx;
    // blue control codes seen during blanking
    logic [3:0]        codes_seen;

    // {shade_sel, gray, selected value}
    logic [16:0] stim_table [table_len];

    `include "tb_tmds_model.svh"

    hdmi_tx_top UUT (
        .clk_pixel  (clk_pixel),
        .rst_n      (rst_n),
        .gray       (gray),
        .shade_sel  (shade_sel),
        .hcount     (hcount),
        .vcount     (vcount),
        .hs         (hs),
        .vs         (vs),
        .ad         (ad),
        .nf         (nf),
        .fc         (fc),
        .tmds_red   (tmds_red),
        .tmds_green (tmds_green),
        .tmds_blue  (tmds_blue)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #2 clk_pixel = ~clk_pixel;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_symbol(input string what, input tmds_pkg::symbol_t expected,
                                input tmds_pkg::symbol_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s %s at h=%0d v=%0d expected %b actual %b",
                test_name, what, exp_h, exp_v, expected, actual));
        end
    endtask

    task automatic check_hcount(input video_pkg::hcount_t expected,
                                input video_pkg::hcount_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s hcount expected %0d actual %0d",
                test_name, expected, actual));
        end
    endtask

    task automatic check_vcount(input video_pkg::vcount_t expected,
                                input video_pkg::vcount_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s vcount expected %0d actual %0d",
                test_name, expected, actual));
        end
    endtask

    task automatic check_frame(input video_pkg::frame_t expected,
                               input video_pkg::frame_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s fc expected %0d actual %0d",
                test_name, expected, actual));
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s %s at h=%0d v=%0d expected %b actual %b",
                test_name, what, exp_h, exp_v, expected, actual));
        end
    endtask

    task automatic load_table();
        stim_table[0]  = {1'b1, 8'h00, 8'h00};
        stim_table[1]  = {1'b1, 8'hFF, 8'hFF};
        stim_table[2]  = {1'b1, 8'hCC, 8'hCC};
        stim_table[3]  = {1'b1, 8'h0F, 8'h0F};
        stim_table[4]  = {1'b1, 8'h10, 8'h10};
        // four ones, d[0] low
        stim_table[5]  = {1'b1, 8'h1E, 8'h1E};
        // four ones, d[0] high
        stim_table[6]  = {1'b1, 8'h55, 8'h55};
        stim_table[7]  = {1'b1, 8'hAA, 8'hAA};
        // flat shade replaces gray
        stim_table[8]  = {1'b0, 8'h3C, 8'hCC};
        stim_table[9]  = {1'b1, 8'hF0, 8'hF0};
        stim_table[10] = {1'b1, 8'h01, 8'h01};
        stim_table[11] = {1'b1, 8'h80, 8'h80};
        stim_table[12] = {1'b0, 8'h00, 8'hCC};
        stim_table[13] = {1'b1, 8'h7F, 8'h7F};
        stim_table[14] = {1'b1, 8'hE1, 8'hE1};
        stim_table[15] = {1'b0, 8'hFF, 8'hCC};
    endtask

    // hold reset, then load the expected reset state
    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clk_pixel);
        rst_n = 1'b1;
        exp_h  = 0;
        exp_v  = 0;
        exp_fc = 0;
        exp_hs = 1'b0;
        exp_vs = 1'b0;
        exp_ad = 1'b0;
        exp_nf = 1'b0;
        px_idx = 0;
        for (int c = 0; c < 3; c++) begin
            exp_sym[c] = '0;
            disp[c]    = 0;
        end
    endtask

    // check one falling edge, drive the next pixel, predict the next edge
    task automatic step_cycle();
        logic [16:0] entry;
        logic [31:0] rnd;
        logic [7:0]  pix;
        logic [8:0]  qm;
        logic [1:0]  ctrl [3];
        check_hcount(video_pkg::hcount_t'(exp_h), hcount);
        check_vcount(video_pkg::vcount_t'(exp_v), vcount);
        check_frame(video_pkg::frame_t'(exp_fc), fc);
        check_flag("hs", exp_hs, hs);
        check_flag("vs", exp_vs, vs);
        check_flag("ad", exp_ad, ad);
        check_flag("nf", exp_nf, nf);
        check_symbol("tmds_red", exp_sym[0], tmds_red);
        check_symbol("tmds_green", exp_sym[1], tmds_green);
        check_symbol("tmds_blue", exp_sym[2], tmds_blue);
        // table first on each active run, random after that
        if (exp_ad && (px_idx < table_len)) begin
            entry     = stim_table[px_idx];
            shade_sel = entry[16];
            gray      = entry[15:8];
            pix       = entry[7:0];
        end else begin
            rnd       = $random(seed);
            gray      = rnd[7:0];
            shade_sel = rnd[8];
            pix       = shade_sel ? gray : 8'hCC;
        end
        px_idx  = exp_ad ? px_idx + 1 : 0;
        ctrl[0] = 2'b00;
        ctrl[1] = 2'b00;
        ctrl[2] = {exp_vs, exp_hs};
        qm      = model_qm(pix);
        for (int c = 0; c < 3; c++) begin
            if (exp_ad) begin
                exp_sym[c] = model_symbol(qm, disp[c]);
                disp[c]    = model_disparity(qm, disp[c]);
            end else begin
                exp_sym[c] = model_ctrl(ctrl[c]);
                disp[c]    = 0;
            end
        end
        if (!exp_ad) begin
            codes_seen[ctrl[2]] = 1'b1;
        end
        // fc moves one cycle behind nf
        if (exp_nf) begin
            exp_fc = (exp_fc + 1) % 60;
        end
        if (exp_h == 1649) begin
            exp_h = 0;
            exp_v = (exp_v == 749) ? 0 : exp_v + 1;
        end else begin
            exp_h = exp_h + 1;
        end
        exp_hs = (exp_h >= 1390) && (exp_h <= 1429);
        exp_vs = (exp_v >= 725) && (exp_v <= 729);
        exp_ad = (exp_h < 1280) && (exp_v < 720);
        exp_nf = (exp_h == 1280) && (exp_v == 720);
        @(negedge clk_pixel);
    endtask

    // watchdog
    always @(posedge clk_pixel) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            report_failure($sformatf("timeout after %0d clock cycles", cycle_count));
        end
    end

    initial begin
        seed      = 32'h173d;
        rst_n     = 1'b0;
        gray      = '0;
        shade_sel = 1'b0;
        load_table();
        test_name = "power-up reset";
        apply_reset();
        // whole frame from reset release
        test_name  = "raster frame";
        codes_seen = '0;
        repeat (frame_cycles) step_cycle();
        if (codes_seen != 4'b1111) begin
            report_failure($sformatf("blue channel showed only control codes %b in a frame",
                codes_seen));
        end
        // stop partway through line 3 of the second frame
        test_name = "second frame";
        repeat (3 * line_cycles + 640) step_cycle();
        test_name = "mid-line reset";
        apply_reset();
        repeat (3 * line_cycles) step_cycle();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verif
common/video_pkg.sv
common/tmds_pkg.sv
hdl/video_sig_gen.sv
tmds/tmds_encoder.sv
hdl/hdmi_tx_top.sv
verif/tb_hdmi_tx_top.sv
